//--- tsc_core.f
+incdir+.
tsc_pkg.sv
tsc_mem_if.sv
tsc_mem_arbiter.sv
tsc_unified_mem.sv
tsc_fetch_unit.sv
tsc_inst_queue.sv
tsc_exec_unit.sv
tsc_core.sv
tb_tsc_core.sv

//--- Bender.yml
package:
  name: tsc_core

sources:
  - files:
      - tsc_pkg.sv
      - tsc_mem_if.sv
      - tsc_mem_arbiter.sv
      - tsc_unified_mem.sv
      - tsc_fetch_unit.sv
      - tsc_inst_queue.sv
      - tsc_exec_unit.sv
      - tsc_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_tsc_core.sv

//--- tb_tsc_tasks.svh
`ifndef TB_TSC_TASKS_SVH
`define TB_TSC_TASKS_SVH

////////////////////////////////////////////////////
// Random source
////////////////////////////////////////////////////

// Galois LFSR, one step per bit taken
function automatic tsc_pkg::word_t rand_bits(input int n);
   tsc_pkg::word_t v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr_q[0]};
      if (lfsr_q[0]) begin
         lfsr_q = (lfsr_q >> 1) ^ 32'hA300_0000;
      end else begin
         lfsr_q = lfsr_q >> 1;
      end
   end
   return v;
endfunction

////////////////////////////////////////////////////
// Instruction encoding
////////////////////////////////////////////////////

// Immediate as the core sees it
function automatic tsc_pkg::word_t sext8(input logic [7:0] v);
   return {{8{v[7]}}, v};
endfunction

// opcode, rs, rt, rd, function
function automatic tsc_pkg::word_t enc_r(input tsc_pkg::func_e fn,
                                         input tsc_pkg::reg_idx_t rs,
                                         input tsc_pkg::reg_idx_t rt,
                                         input tsc_pkg::reg_idx_t rd);
   return {tsc_pkg::OP_RTYPE, rs, rt, rd, fn};
endfunction

// opcode, rs, rt, 8-bit immediate
function automatic tsc_pkg::word_t enc_i(input tsc_pkg::opcode_e op,
                                         input tsc_pkg::reg_idx_t rs,
                                         input tsc_pkg::reg_idx_t rt,
                                         input logic [7:0] imm);
   return {op, rs, rt, imm};
endfunction

// opcode, 12-bit target
function automatic tsc_pkg::word_t enc_j(input tsc_pkg::opcode_e op,
                                         input logic [11:0] tgt);
   return {op, tgt};
endfunction

////////////////////////////////////////////////////
// Program image
////////////////////////////////////////////////////

task automatic clear_program();
   prog.delete();
   exp_q.delete();
   got_q.delete();
   exp_count = 0;
endtask

// Next word in the image, counted if it lies on the executed path
task automatic emit(input tsc_pkg::word_t inst, input logic on_path);
   prog.push_back(inst);
   if (on_path) begin
      exp_count++;
   end
endtask

////////////////////////////////////////////////////
// Checks
////////////////////////////////////////////////////

task automatic compare_word(input tsc_pkg::word_t got, input tsc_pkg::word_t exp,
                            input string msg);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("Fail %0t: %s got %h expected %h", $time, msg, got, exp);
   end
endtask

task automatic compare_bit(input logic got, input logic exp, input string msg);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("Fail %0t: %s got %b expected %b", $time, msg, got, exp);
   end
endtask

////////////////////////////////////////////////////
// Load, run, collect
////////////////////////////////////////////////////

task automatic run_program(input string name);
   int cycles;
   @(posedge clk);
   #2;
   reset_n = 1'b0;
   // Loader writes while the core sits in reset
   for (int i = 0; i < prog.size(); i++) begin
      i_load_we   = 1'b1;
      i_load_addr = tsc_pkg::word_t'(i);
      i_load_data = prog[i];
      @(posedge clk);
      #2;
   end
   i_load_we = 1'b0;
   repeat (3) @(posedge clk);
   #2;
   reset_n = 1'b1;

   // Outputs sampled mid-cycle
   cycles = 0;
   while (!o_halted && cycles < RUN_LIMIT) begin
      @(negedge clk);
      if (o_output_valid) begin
         got_q.push_back(o_output_port);
      end
      cycles++;
   end
   if (!o_halted) begin
      timeouts++;
      $display("Timeout: %s did not halt within %0d cycles", name, RUN_LIMIT);
      return;
   end

   // Halt holds, nothing after it runs
   for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      compare_bit(o_halted, 1'b1, {name, " halted after HLT"});
      compare_bit(o_output_valid, 1'b0, {name, " output after HLT"});
   end

   compare_word(tsc_pkg::word_t'(got_q.size()), tsc_pkg::word_t'(exp_q.size()),
                {name, " output count"});
   for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      compare_word(got_q[i], exp_q[i], $sformatf("%s output %0d", name, i));
   end
   compare_word(o_num_inst, tsc_pkg::word_t'(exp_count), {name, " retired count"});
endtask

`endif

//--- tb_tsc_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tsc_core;
   // Cycles allowed from reset release to halt
   localparam int RUN_LIMIT = 500;

   logic           clk;
   logic           reset_n;
   logic           i_load_we;
   tsc_pkg::word_t i_load_addr;
   tsc_pkg::word_t i_load_data;
   tsc_pkg::word_t o_output_port;
   logic           o_output_valid;
   logic           o_halted;
   tsc_pkg::word_t o_num_inst;

   // Image, expected and observed output streams
   tsc_pkg::word_t prog [$];
   tsc_pkg::word_t exp_q [$];
   tsc_pkg::word_t got_q [$];
   int             exp_count;
   int             checks;
   int             errors;
   int             timeouts;
   logic [31:0]    lfsr_q;

   tsc_core i_dut (
      .clk            (clk),
      .reset_n        (reset_n),
      .i_load_we      (i_load_we),
      .i_load_addr    (i_load_addr),
      .i_load_data    (i_load_data),
      .o_output_port  (o_output_port),
      .o_output_valid (o_output_valid),
      .o_halted       (o_halted),
      .o_num_inst     (o_num_inst)
   );

   `include "tb_tsc_tasks.svh"

   // 40 ns period
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   ////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////

   task automatic test_arithmetic();
      tsc_pkg::word_t m0, m1, m2, m3;
      logic [7:0]     hi0, lo0, hi1, im1, im2;
      clear_program();
      hi0 = 8'(rand_bits(8));
      lo0 = 8'(rand_bits(8));
      hi1 = 8'(rand_bits(8));
      im1 = 8'(rand_bits(8));
      im2 = 8'(rand_bits(8));
      // Operands from LHI with ORI and ADI
      emit(enc_i(tsc_pkg::OP_LHI, 2'd0, 2'd0, hi0), 1'b1);
      emit(enc_i(tsc_pkg::OP_ORI, 2'd0, 2'd0, lo0), 1'b1);
      emit(enc_i(tsc_pkg::OP_LHI, 2'd0, 2'd1, hi1), 1'b1);
      emit(enc_i(tsc_pkg::OP_ADI, 2'd1, 2'd1, im1), 1'b1);
      m0 = {hi0, 8'h00} | sext8(lo0);
      m1 = {hi1, 8'h00} + sext8(im1);
      emit(enc_r(tsc_pkg::FN_WWD, 2'd0, 2'd0, 2'd0), 1'b1);
      emit(enc_r(tsc_pkg::FN_WWD, 2'd1, 2'd0, 2'd0), 1'b1);
      exp_q.push_back(m0);
      exp_q.push_back(m1);
      // Wrapping 16-bit model
      emit(enc_r(tsc_pkg::FN_ADD, 2'd0, 2'd1, 2'd2), 1'b1);
      emit(enc_r(tsc_pkg::FN_WWD, 2'd2, 2'd0, 2'd0), 1'b1);
      m2 = m0 + m1;
      exp_q.push_back(m2);
      emit(enc_r(tsc_pkg::FN_SUB, 2'd0, 2'd1, 2'd3), 1'b1);
      emit(enc_r(tsc_pkg::FN_WWD, 2'd3, 2'd0, 2'd0), 1'b1);
      m3 = m0 - m1;
      exp_q.push_back(m3);
      emit(enc_r(tsc_pkg::FN_AND, 2'd3, 2'd0, 2'd2), 1'b1);
      emit(enc_r(tsc_pkg::FN_WWD, 2'd2, 2'd0, 2'd0), 1'b1);
      m2 = m3 & m0;
      exp_q.push_back(m2);
      emit(enc_r(tsc_pkg::FN_ORR, 2'd2, 2'd1, 2'd3), 1'b1);
      emit(enc_r(tsc_pkg::FN_WWD, 2'd3, 2'd0, 2'd0), 1'b1);
      m3 = m2 | m1;
      exp_q.push_back(m3);
      emit(enc_i(tsc_pkg::OP_ADI, 2'd3, 2'd0, im2), 1'b1);
      emit(enc_r(tsc_pkg::FN_WWD, 2'd0, 2'd0, 2'd0), 1'b1);
      m0 = m3 + sext8(im2);
      exp_q.push_back(m0);
      emit(enc_r(tsc_pkg::FN_HLT, 2'd0, 2'd0, 2'd0), 1'b1);
      run_program("arithmetic");
   endtask

   task automatic test_memory();
      tsc_pkg::word_t    vals [3];
      logic [7:0]        offs [3];
      logic [7:0]        hi;
      logic [7:0]        lo;
      tsc_pkg::reg_idx_t dst;
      clear_program();
      // r3 is the data base, well above the image
      emit(enc_i(tsc_pkg::OP_ORI, 2'd3, 2'd3, 8'h40), 1'b1);
      for (int i = 0; i < 3; i++) begin
         hi      = 8'(rand_bits(8));
         lo      = 8'(rand_bits(8));
         offs[i] = 8'(i * 4) + 8'(rand_bits(2));
         vals[i] = {hi, 8'h00} | sext8(lo);
         emit(enc_i(tsc_pkg::OP_LHI, 2'd0, 2'd0, hi), 1'b1);
         emit(enc_i(tsc_pkg::OP_ORI, 2'd0, 2'd0, lo), 1'b1);
         emit(enc_i(tsc_pkg::OP_SWD, 2'd3, 2'd0, offs[i]), 1'b1);
      end
      // Newest first, into r1 and r2 in turn
      for (int i = 2; i >= 0; i--) begin
         dst = tsc_pkg::reg_idx_t'(1 + i % 2);
         emit(enc_i(tsc_pkg::OP_LWD, 2'd3, dst, offs[i]), 1'b1);
         emit(enc_r(tsc_pkg::FN_WWD, dst, 2'd0, 2'd0), 1'b1);
         exp_q.push_back(vals[i]);
      end
      emit(enc_r(tsc_pkg::FN_HLT, 2'd0, 2'd0, 2'd0), 1'b1);
      run_program("memory");
   endtask

   task automatic test_branches();
      logic [7:0] hi;
      logic [7:0] lo;
      clear_program();
      // Upper byte never 8'hBA, so r0 differs from the marker
      hi = 8'(rand_bits(7));
      lo = 8'(rand_bits(8));
      emit(enc_i(tsc_pkg::OP_LHI, 2'd0, 2'd0, hi), 1'b1);
      emit(enc_i(tsc_pkg::OP_ORI, 2'd0, 2'd0, lo), 1'b1);
      emit(enc_i(tsc_pkg::OP_ORI, 2'd0, 2'd1, 8'h00), 1'b1);
      // r2 holds the wrong-path marker
      emit(enc_i(tsc_pkg::OP_LHI, 2'd0, 2'd2, 8'hBA), 1'b1);
      // BEQ taken over a marker
      emit(enc_i(tsc_pkg::OP_BEQ, 2'd0, 2'd1, 8'd1), 1'b1);
      emit(enc_r(tsc_pkg::FN_WWD, 2'd2, 2'd0, 2'd0), 1'b0);
      emit(enc_i(tsc_pkg::OP_ADI, 2'd3, 2'd3, 8'd1), 1'b1);
      emit(enc_r(tsc_pkg::FN_WWD, 2'd3, 2'd0, 2'd0), 1'b1);
      exp_q.push_back(16'd1);
      // BNE taken over a marker
      emit(enc_i(tsc_pkg::OP_BNE, 2'd0, 2'd2, 8'd1), 1'b1);
      emit(enc_r(tsc_pkg::FN_WWD, 2'd2, 2'd0, 2'd0), 1'b0);
      emit(enc_i(tsc_pkg::OP_ADI, 2'd3, 2'd3, 8'd1), 1'b1);
      // BEQ not taken, falls into two slots
      emit(enc_i(tsc_pkg::OP_BEQ, 2'd0, 2'd2, 8'd2), 1'b1);
      emit(enc_r(tsc_pkg::FN_WWD, 2'd3, 2'd0, 2'd0), 1'b1);
      exp_q.push_back(16'd2);
      emit(enc_i(tsc_pkg::OP_ADI, 2'd3, 2'd3, 8'd1), 1'b1);
      // BNE not taken
      emit(enc_i(tsc_pkg::OP_BNE, 2'd0, 2'd1, 8'd1), 1'b1);
      emit(enc_r(tsc_pkg::FN_WWD, 2'd3, 2'd0, 2'd0), 1'b1);
      exp_q.push_back(16'd3);
      emit(enc_r(tsc_pkg::FN_HLT, 2'd0, 2'd0, 2'd0), 1'b1);
      run_program("branches");
   endtask

   task automatic test_jumps();
      int jal_pc;
      int jrl_pc;
      clear_program();
      jal_pc = 2;
      jrl_pc = 10;
      emit(enc_i(tsc_pkg::OP_LHI, 2'd0, 2'd0, 8'hBA), 1'b1);        // 0
      emit(enc_i(tsc_pkg::OP_ORI, 2'd3, 2'd3, 8'd1), 1'b1);         // 1
      emit(enc_j(tsc_pkg::OP_JAL, 12'd6), 1'b1);                    // 2
      emit(enc_r(tsc_pkg::FN_WWD, 2'd3, 2'd0, 2'd0), 1'b1);         // 3
      emit(enc_j(tsc_pkg::OP_JMP, 12'd9), 1'b1);                    // 4
      emit(enc_r(tsc_pkg::FN_WWD, 2'd0, 2'd0, 2'd0), 1'b0);         // 5
      emit(enc_r(tsc_pkg::FN_WWD, 2'd2, 2'd0, 2'd0), 1'b1);         // 6
      emit(enc_i(tsc_pkg::OP_ADI, 2'd3, 2'd3, 8'd1), 1'b1);         // 7
      emit(enc_r(tsc_pkg::FN_JPR, 2'd2, 2'd0, 2'd0), 1'b1);         // 8
      emit(enc_i(tsc_pkg::OP_ORI, 2'd1, 2'd1, 8'd13), 1'b1);        // 9
      emit(enc_r(tsc_pkg::FN_JRL, 2'd1, 2'd0, 2'd0), 1'b1);         // 10
      emit(enc_r(tsc_pkg::FN_WWD, 2'd3, 2'd0, 2'd0), 1'b1);         // 11
      emit(enc_r(tsc_pkg::FN_HLT, 2'd0, 2'd0, 2'd0), 1'b1);         // 12
      emit(enc_r(tsc_pkg::FN_WWD, 2'd2, 2'd0, 2'd0), 1'b1);         // 13
      emit(enc_i(tsc_pkg::OP_ADI, 2'd3, 2'd3, 8'd1), 1'b1);         // 14
      emit(enc_r(tsc_pkg::FN_JPR, 2'd2, 2'd0, 2'd0), 1'b1);         // 15
      emit(enc_r(tsc_pkg::FN_WWD, 2'd0, 2'd0, 2'd0), 1'b0);         // 16
      // Path 2, 6, 7, 8, 3, 4, 9, 10, 13, 14, 15, 11, 12
      exp_q.push_back(tsc_pkg::word_t'(jal_pc + 1));
      exp_q.push_back(16'd2);
      exp_q.push_back(tsc_pkg::word_t'(jrl_pc + 1));
      exp_q.push_back(16'd3);
      run_program("jumps");
   endtask

   task automatic test_halt();
      logic [7:0] imm;
      clear_program();
      imm = 8'(rand_bits(8));
      emit(enc_i(tsc_pkg::OP_ORI, 2'd0, 2'd0, imm), 1'b1);
      emit(enc_r(tsc_pkg::FN_WWD, 2'd0, 2'd0, 2'd0), 1'b1);
      exp_q.push_back(sext8(imm));
      emit(enc_i(tsc_pkg::OP_ADI, 2'd0, 2'd0, 8'd1), 1'b1);
      emit(enc_r(tsc_pkg::FN_HLT, 2'd0, 2'd0, 2'd0), 1'b1);
      // Fetched behind HLT but never retired
      emit(enc_r(tsc_pkg::FN_WWD, 2'd0, 2'd0, 2'd0), 1'b0);
      emit(enc_i(tsc_pkg::OP_ADI, 2'd0, 2'd0, 8'd1), 1'b0);
      emit(enc_r(tsc_pkg::FN_WWD, 2'd0, 2'd0, 2'd0), 1'b0);
      run_program("halt");
   endtask

   ////////////////////////////////////////////////////
   // Sequence
   ////////////////////////////////////////////////////

   initial begin
      reset_n     = 1'b0;
      i_load_we   = 1'b0;
      i_load_addr = '0;
      i_load_data = '0;
      checks      = 0;
      errors      = 0;
      timeouts    = 0;
      exp_count   = 0;
      lfsr_q      = 32'h3bff686e;

      test_arithmetic();
      test_memory();
      test_branches();
      test_jumps();
      test_halt();

      $display("Checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tsc_core.sv
`timescale 1ns/1ps
`default_nettype none

module tsc_core (
   input  logic           clk,
   input  logic           reset_n,
   input  logic           i_load_we,
   input  tsc_pkg::word_t i_load_addr,
   input  tsc_pkg::word_t i_load_data,
   output tsc_pkg::word_t o_output_port,
   output logic           o_output_valid,
   output logic           o_halted,
   output tsc_pkg::word_t o_num_inst
);
   tsc_mem_if load_if ();
   tsc_mem_if fetch_if ();
   tsc_mem_if data_if ();

   logic           mem_we;
   tsc_pkg::word_t mem_addr;
   tsc_pkg::word_t mem_wdata;
   tsc_pkg::word_t mem_rdata;
   // Fetch to queue
   logic           push;
   tsc_pkg::word_t push_inst;
   tsc_pkg::word_t push_pc;
   logic           credit_return;
   // Queue head to execute
   logic           iq_valid;
   tsc_pkg::word_t iq_inst;
   tsc_pkg::word_t iq_pc;
   logic           pop;
   // Execute back to the front end
   logic           redirect;
   tsc_pkg::word_t redirect_pc;

   ////////////////////////////////////////////////////
   // Program loader, write-only and always first
   ////////////////////////////////////////////////////

   assign load_if.req   = i_load_we;
   assign load_if.we    = i_load_we;
   assign load_if.addr  = i_load_addr;
   assign load_if.wdata = i_load_data;

   tsc_mem_arbiter i_arbiter (
      .clk         (clk),
      .reset_n     (reset_n),
      .load_port   (load_if.arbiter),
      .fetch_port  (fetch_if.arbiter),
      .data_port   (data_if.arbiter),
      .o_mem_we    (mem_we),
      .o_mem_addr  (mem_addr),
      .o_mem_wdata (mem_wdata),
      .i_mem_rdata (mem_rdata)
   );

   // Array keeps its contents through reset
   tsc_unified_mem i_mem (
      .clk     (clk),
      .i_we    (mem_we),
      .i_addr  (mem_addr),
      .i_wdata (mem_wdata),
      .o_rdata (mem_rdata)
   );

   tsc_fetch_unit i_fetch (
      .clk             (clk),
      .reset_n         (reset_n),
      .mem             (fetch_if.requester),
      .i_redirect      (redirect),
      .i_redirect_pc   (redirect_pc),
      .i_credit_return (credit_return),
      .o_push          (push),
      .o_push_inst     (push_inst),
      .o_push_pc       (push_pc)
   );

   // Redirect doubles as the queue flush
   tsc_inst_queue i_queue (
      .clk             (clk),
      .reset_n         (reset_n),
      .i_flush         (redirect),
      .i_push          (push),
      .i_push_inst     (push_inst),
      .i_push_pc       (push_pc),
      .i_pop           (pop),
      .o_valid         (iq_valid),
      .o_inst          (iq_inst),
      .o_pc            (iq_pc),
      .o_credit_return (credit_return)
   );

   tsc_exec_unit i_exec (
      .clk            (clk),
      .reset_n        (reset_n),
      .i_valid        (iq_valid),
      .i_inst         (iq_inst),
      .i_pc           (iq_pc),
      .o_pop          (pop),
      .data_port      (data_if.requester),
      .o_redirect     (redirect),
      .o_redirect_pc  (redirect_pc),
      .o_output_port  (o_output_port),
      .o_output_valid (o_output_valid),
      .o_halted       (o_halted),
      .o_num_inst     (o_num_inst)
   );

endmodule

`default_nettype wire

//--- tsc_exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tsc_exec_unit (
   input  logic           clk,
   input  logic           reset_n,
   input  logic           i_valid,
   input  tsc_pkg::word_t i_inst,
   input  tsc_pkg::word_t i_pc,
   output logic           o_pop,
   tsc_mem_if.requester   data_port,
   output logic           o_redirect,
   output tsc_pkg::word_t o_redirect_pc,
   output tsc_pkg::word_t o_output_port,
   output logic           o_output_valid,
   output logic           o_halted,
   output tsc_pkg::word_t o_num_inst
);
   tsc_pkg::exec_state_e state_q;
   tsc_pkg::exec_state_e state_d;
   tsc_pkg::opcode_e     opcode;
   tsc_pkg::func_e       func;
   tsc_pkg::reg_idx_t    rs;
   tsc_pkg::reg_idx_t    rt;
   tsc_pkg::reg_idx_t    rd;
   tsc_pkg::word_t       imm_sext;
   tsc_pkg::word_t       jump_target;
   tsc_pkg::word_t       pc_plus1;
   tsc_pkg::word_t       rs_val;
   tsc_pkg::word_t       rt_val;
   tsc_pkg::word_t       alu_result;
   tsc_pkg::word_t       rf [4];
   logic                 is_mem;
   logic                 is_store;
   logic                 rf_we;
   tsc_pkg::reg_idx_t    rf_waddr;
   tsc_pkg::word_t       rf_wdata;

   ////////////////////////////////////////////////////
   // Decode
   ////////////////////////////////////////////////////

   assign opcode = tsc_pkg::opcode_e'(i_inst[tsc_pkg::OPC_MSB:tsc_pkg::OPC_LSB]);
   assign func   = tsc_pkg::func_e'(i_inst[tsc_pkg::FUNC_MSB:tsc_pkg::FUNC_LSB]);
   assign rs     = i_inst[tsc_pkg::RS_MSB:tsc_pkg::RS_LSB];
   assign rt     = i_inst[tsc_pkg::RT_MSB:tsc_pkg::RT_LSB];
   assign rd     = i_inst[tsc_pkg::RD_MSB:tsc_pkg::RD_LSB];

   assign imm_sext    = {{8{i_inst[tsc_pkg::IMM_MSB]}},
                         i_inst[tsc_pkg::IMM_MSB:tsc_pkg::IMM_LSB]};
   // Stays within the current 4K page
   assign jump_target = {i_pc[15:12], i_inst[tsc_pkg::TGT_MSB:tsc_pkg::TGT_LSB]};
   assign pc_plus1    = i_pc + 1'b1;

   assign rs_val = rf[rs];
   assign rt_val = rf[rt];

   assign is_store = (opcode == tsc_pkg::OP_SWD);
   assign is_mem   = (opcode == tsc_pkg::OP_LWD) | is_store;

   // Data port, base register plus offset
   assign data_port.we    = is_store;
   assign data_port.addr  = rs_val + imm_sext;
   assign data_port.wdata = rt_val;

   // R-type ALU
   always_comb begin
      case (func)
         tsc_pkg::FN_SUB: alu_result = rs_val - rt_val;
         tsc_pkg::FN_AND: alu_result = rs_val & rt_val;
         tsc_pkg::FN_ORR: alu_result = rs_val | rt_val;
         default:         alu_result = rs_val + rt_val;
      endcase
   end

   // WWD source, qualified by o_output_valid
   assign o_output_port = rs_val;
   assign o_halted      = (state_q == tsc_pkg::EXEC_HALTED);

   ////////////////////////////////////////////////////
   // Execute FSM
   ////////////////////////////////////////////////////

   always_comb begin
      state_d        = state_q;
      o_pop          = 1'b0;
      o_redirect     = 1'b0;
      // Branch target by default
      o_redirect_pc  = pc_plus1 + imm_sext;
      o_output_valid = 1'b0;
      rf_we          = 1'b0;
      rf_waddr       = rd;
      rf_wdata       = alu_result;
      data_port.req  = 1'b0;
      case (state_q)
         tsc_pkg::EXEC_RUN: begin
            if (i_valid && is_mem) begin
               // Held until granted
               data_port.req = 1'b1;
               if (data_port.gnt) begin
                  if (is_store) begin
                     o_pop = 1'b1;
                  end else begin
                     state_d = tsc_pkg::EXEC_MEM_WAIT;
                  end
               end
            end else if (i_valid) begin
               // Single-cycle instructions retire now
               o_pop = 1'b1;
               case (opcode)
                  tsc_pkg::OP_RTYPE: begin
                     case (func)
                        tsc_pkg::FN_ADD, tsc_pkg::FN_SUB,
                        tsc_pkg::FN_AND, tsc_pkg::FN_ORR: rf_we = 1'b1;
                        tsc_pkg::FN_WWD: o_output_valid = 1'b1;
                        tsc_pkg::FN_JPR: begin
                           o_redirect    = 1'b1;
                           o_redirect_pc = rs_val;
                        end
                        tsc_pkg::FN_JRL: begin
                           o_redirect    = 1'b1;
                           o_redirect_pc = rs_val;
                           rf_we         = 1'b1;
                           rf_waddr      = 2'd2;
                           rf_wdata      = pc_plus1;
                        end
                        // Nothing older is in flight
                        tsc_pkg::FN_HLT: state_d = tsc_pkg::EXEC_HALTED;
                        default: ;
                     endcase
                  end
                  tsc_pkg::OP_ADI: begin
                     rf_we    = 1'b1;
                     rf_waddr = rt;
                     rf_wdata = rs_val + imm_sext;
                  end
                  tsc_pkg::OP_ORI: begin
                     rf_we    = 1'b1;
                     rf_waddr = rt;
                     rf_wdata = rs_val | imm_sext;
                  end
                  tsc_pkg::OP_LHI: begin
                     rf_we    = 1'b1;
                     rf_waddr = rt;
                     rf_wdata = {i_inst[tsc_pkg::IMM_MSB:tsc_pkg::IMM_LSB], 8'h00};
                  end
                  tsc_pkg::OP_BNE: o_redirect = (rs_val != rt_val);
                  tsc_pkg::OP_BEQ: o_redirect = (rs_val == rt_val);
                  tsc_pkg::OP_JMP: begin
                     o_redirect    = 1'b1;
                     o_redirect_pc = jump_target;
                  end
                  tsc_pkg::OP_JAL: begin
                     o_redirect    = 1'b1;
                     o_redirect_pc = jump_target;
                     // Link register is r2
                     rf_we         = 1'b1;
                     rf_waddr      = 2'd2;
                     rf_wdata      = pc_plus1;
                  end
                  // Unknown opcodes retire as no-ops
                  default: ;
               endcase
            end
         end
         tsc_pkg::EXEC_MEM_WAIT: begin
            // LWD stays at the head until its data returns
            if (data_port.rvalid) begin
               o_pop    = 1'b1;
               rf_we    = 1'b1;
               rf_waddr = rt;
               rf_wdata = data_port.rdata;
               state_d  = tsc_pkg::EXEC_RUN;
            end
         end
         // Halted, the queue is never popped again
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state_q    <= tsc_pkg::EXEC_RUN;
         o_num_inst <= '0;
         rf         <= '{default: '0};
      end else begin
         state_q <= state_d;
         // Every pop is a retire
         if (o_pop) begin
            o_num_inst <= o_num_inst + 1'b1;
         end
         if (rf_we) begin
            rf[rf_waddr] <= rf_wdata;
         end
      end
   end

endmodule

`default_nettype wire

//--- tsc_inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module tsc_inst_queue (
   input  logic           clk,
   input  logic           reset_n,
   input  logic           i_flush,
   input  logic           i_push,
   input  tsc_pkg::word_t i_push_inst,
   input  tsc_pkg::word_t i_push_pc,
   input  logic           i_pop,
   output logic           o_valid,
   output tsc_pkg::word_t o_inst,
   output tsc_pkg::word_t o_pc,
   output logic           o_credit_return
);
   tsc_pkg::word_t inst_mem [tsc_pkg::IQ_DEPTH];
   tsc_pkg::word_t pc_mem   [tsc_pkg::IQ_DEPTH];
   // Extra bit tells full from empty
   logic [tsc_pkg::IQ_PTR_W:0] wr_ptr_q;
   logic [tsc_pkg::IQ_PTR_W:0] rd_ptr_q;
   logic                       do_pop;

   assign o_valid = (wr_ptr_q != rd_ptr_q);
   assign do_pop  = i_pop & o_valid;

   // Head entry
   assign o_inst = inst_mem[rd_ptr_q[tsc_pkg::IQ_PTR_W-1:0]];
   assign o_pc   = pc_mem[rd_ptr_q[tsc_pkg::IQ_PTR_W-1:0]];

   // Each pop frees a slot for fetch
   assign o_credit_return = do_pop;

   always_ff @(posedge clk) begin
      if (!reset_n || i_flush) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         // Fetch credits keep this from overflowing
         if (i_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_push) begin
         inst_mem[wr_ptr_q[tsc_pkg::IQ_PTR_W-1:0]] <= i_push_inst;
         pc_mem[wr_ptr_q[tsc_pkg::IQ_PTR_W-1:0]]   <= i_push_pc;
      end
   end

endmodule

`default_nettype wire

//--- tsc_fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tsc_fetch_unit (
   input  logic           clk,
   input  logic           reset_n,
   tsc_mem_if.requester   mem,
   input  logic           i_redirect,
   input  tsc_pkg::word_t i_redirect_pc,
   input  logic           i_credit_return,
   output logic           o_push,
   output tsc_pkg::word_t o_push_inst,
   output tsc_pkg::word_t o_push_pc
);
   tsc_pkg::word_t               pc_q;
   // Address of the read in flight
   tsc_pkg::word_t               inflight_pc_q;
   logic [tsc_pkg::CREDIT_W-1:0] credit_q;
   logic                         issue;
   logic                         stale_rsp;

   ////////////////////////////////////////////////////
   // Request side
   ////////////////////////////////////////////////////

   // Read-only requester
   assign mem.we    = 1'b0;
   assign mem.wdata = '0;
   assign mem.addr  = pc_q;

   // One credit per read, none issued while redirecting
   assign mem.req = (credit_q != '0) & ~i_redirect;
   assign issue   = mem.req & mem.gnt;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         pc_q     <= '0;
         credit_q <= tsc_pkg::CREDIT_W'(tsc_pkg::IQ_DEPTH);
      end else if (i_redirect) begin
         pc_q     <= i_redirect_pc;
         // Queue flushed and stale response dropped, so all credits are back
         credit_q <= tsc_pkg::CREDIT_W'(tsc_pkg::IQ_DEPTH);
      end else begin
         if (issue) begin
            pc_q <= pc_q + 1'b1;
         end
         // Take on issue, give back on pop
         case ({issue, i_credit_return})
            2'b10:   credit_q <= credit_q - 1'b1;
            2'b01:   credit_q <= credit_q + 1'b1;
            default: credit_q <= credit_q;
         endcase
      end
   end

   // Tag the issued address for the push
   always_ff @(posedge clk) begin
      if (issue) begin
         inflight_pc_q <= pc_q;
      end
   end

   ////////////////////////////////////////////////////
   // Response side
   ////////////////////////////////////////////////////

   // Response landing with a redirect belongs to the old path
   assign stale_rsp = mem.rvalid & i_redirect;

   assign o_push      = mem.rvalid & ~stale_rsp;
   assign o_push_inst = mem.rdata;
   assign o_push_pc   = inflight_pc_q;

endmodule

`default_nettype wire

//--- tsc_unified_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tsc_unified_mem (
   input  logic           clk,
   input  logic           i_we,
   input  tsc_pkg::word_t i_addr,
   input  tsc_pkg::word_t i_wdata,
   output tsc_pkg::word_t o_rdata
);
   tsc_pkg::word_t mem [tsc_pkg::MEM_DEPTH];
   logic [tsc_pkg::MEM_ADDR_W-1:0] word_addr;

   // Upper address bits ignored
   assign word_addr = i_addr[tsc_pkg::MEM_ADDR_W-1:0];

   // Single port, registered read
   always_ff @(posedge clk) begin
      if (i_we) begin
         mem[word_addr] <= i_wdata;
      end
      // Read is old data on a same-address write
      o_rdata <= mem[word_addr];
   end

endmodule

`default_nettype wire

//--- tsc_mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module tsc_mem_arbiter (
   input  logic           clk,
   input  logic           reset_n,
   tsc_mem_if.arbiter     load_port,
   tsc_mem_if.arbiter     fetch_port,
   tsc_mem_if.arbiter     data_port,
   output logic           o_mem_we,
   output tsc_pkg::word_t o_mem_addr,
   output tsc_pkg::word_t o_mem_wdata,
   input  tsc_pkg::word_t i_mem_rdata
);
   logic load_gnt;
   logic data_gnt;
   logic fetch_gnt;
   // Owner of the read now in the memory
   logic load_rd_q;
   logic data_rd_q;
   logic fetch_rd_q;

   ////////////////////////////////////////////////////
   // Fixed priority, load over data over fetch
   ////////////////////////////////////////////////////

   assign load_gnt  = load_port.req;
   assign data_gnt  = data_port.req & ~load_port.req;
   assign fetch_gnt = fetch_port.req & ~load_port.req & ~data_port.req;

   assign load_port.gnt  = load_gnt;
   assign data_port.gnt  = data_gnt;
   assign fetch_port.gnt = fetch_gnt;

   // Memory follows the winner
   always_comb begin
      o_mem_we    = fetch_gnt & fetch_port.we;
      o_mem_addr  = fetch_port.addr;
      o_mem_wdata = fetch_port.wdata;
      if (load_gnt) begin
         o_mem_we    = load_port.we;
         o_mem_addr  = load_port.addr;
         o_mem_wdata = load_port.wdata;
      end else if (data_gnt) begin
         o_mem_we    = data_port.we;
         o_mem_addr  = data_port.addr;
         o_mem_wdata = data_port.wdata;
      end
   end

   ////////////////////////////////////////////////////
   // Read return routing
   ////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         load_rd_q  <= 1'b0;
         data_rd_q  <= 1'b0;
         fetch_rd_q <= 1'b0;
      end else begin
         // Writes finish at the grant, only reads come back
         load_rd_q  <= load_gnt & ~load_port.we;
         data_rd_q  <= data_gnt & ~data_port.we;
         fetch_rd_q <= fetch_gnt & ~fetch_port.we;
      end
   end

   assign load_port.rvalid  = load_rd_q;
   assign data_port.rvalid  = data_rd_q;
   assign fetch_port.rvalid = fetch_rd_q;

   // Shared data bus, rvalid picks the owner
   assign load_port.rdata  = i_mem_rdata;
   assign data_port.rdata  = i_mem_rdata;
   assign fetch_port.rdata = i_mem_rdata;

endmodule

`default_nettype wire

//--- tsc_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

// One memory requester to the arbiter
interface tsc_mem_if;
   // Requester side, held until granted
   logic           req;
   logic           we;
   tsc_pkg::word_t addr;
   tsc_pkg::word_t wdata;
   // Arbiter side
   logic           gnt;
   // Read data, one cycle after the grant
   logic           rvalid;
   tsc_pkg::word_t rdata;

   modport requester (
      output req, we, addr, wdata,
      input  gnt, rvalid, rdata
   );

   modport arbiter (
      input  req, we, addr, wdata,
      output gnt, rvalid, rdata
   );
endinterface

`default_nettype wire

//--- tsc_pkg.sv
`default_nettype none

package tsc_pkg;

   ////////////////////////////////////////////////////
   // Widths and sizes
   ////////////////////////////////////////////////////

   localparam int WORD_W     = 16;
   localparam int MEM_DEPTH  = 256;
   // Memory decodes only the low address bits
   localparam int MEM_ADDR_W = 8;
   // Queue depth, also the credit count fetch starts with
   localparam int IQ_DEPTH   = 4;
   localparam int IQ_PTR_W   = 2;
   // Credit counter must hold 0 to IQ_DEPTH
   localparam int CREDIT_W   = 3;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [1:0]        reg_idx_t;

   ////////////////////////////////////////////////////
   // Instruction fields
   ////////////////////////////////////////////////////

   localparam int OPC_MSB  = 15;
   localparam int OPC_LSB  = 12;
   localparam int RS_MSB   = 11;
   localparam int RS_LSB   = 10;
   localparam int RT_MSB   = 9;
   localparam int RT_LSB   = 8;
   localparam int RD_MSB   = 7;
   localparam int RD_LSB   = 6;
   localparam int FUNC_MSB = 5;
   localparam int FUNC_LSB = 0;
   // Immediate is sign-extended at decode
   localparam int IMM_MSB  = 7;
   localparam int IMM_LSB  = 0;
   // Jump target, upper 4 bits come from the instruction's address
   localparam int TGT_MSB  = 11;
   localparam int TGT_LSB  = 0;

   ////////////////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////////////////

   typedef enum logic [3:0] {
      OP_BNE   = 4'd0,
      OP_BEQ   = 4'd1,
      OP_ADI   = 4'd4,
      OP_ORI   = 4'd5,
      OP_LHI   = 4'd6,
      OP_LWD   = 4'd7,
      OP_SWD   = 4'd8,
      OP_JMP   = 4'd9,
      OP_JAL   = 4'd10,
      OP_RTYPE = 4'd15
   } opcode_e;

   // Function field of R-type
   typedef enum logic [5:0] {
      FN_ADD = 6'd0,
      FN_SUB = 6'd1,
      FN_AND = 6'd2,
      FN_ORR = 6'd3,
      FN_JPR = 6'd25,
      FN_JRL = 6'd26,
      FN_WWD = 6'd28,
      FN_HLT = 6'd29
   } func_e;

   typedef enum logic [1:0] {
      EXEC_RUN,
      EXEC_MEM_WAIT,
      EXEC_HALTED
   } exec_state_e;

endpackage

`default_nettype wire
